// File: project.f
+incdir+hw
hw/axi_bridge_pkg.sv
hw/meta_fifo.sv
hw/axi_to_lite_ctrl.sv
hw/lite_reg_bank.sv
hw/axi_lite_subsys_top.sv
tests/tb_axi_lite_subsys.sv

// File: tests/tb_axi_lite_subsys.sv
// Bridge tile testbench
`timescale 1ns/100ps

`include "axi_lite_macros.svh"

module tb_axi_lite_subsys import axi_bridge_pkg::*; ();

  localparam int CLK_PERIOD    = 20;
  localparam int NUM_OPS       = 2000;
  localparam int CYCLES_PER_OP = 40;
  // Bound on the final drain with both ready signals open
  localparam int DRAIN_CYCLES  = 64;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      s_aw_valid_i, s_aw_ready_o, s_w_valid_i, s_w_ready_o;
  id_t       s_aw_id_i, s_ar_id_i, s_b_id_o, s_r_id_o;
  addr_t     s_aw_addr_i, s_ar_addr_i;
  user_t     s_aw_user_i, s_ar_user_i, s_b_user_o, s_r_user_o;
  data_t     s_w_data_i, s_r_data_o;
  strb_t     s_w_strb_i;
  logic      s_b_valid_o, s_b_ready_i, s_ar_valid_i, s_ar_ready_o;
  logic      s_r_valid_o, s_r_ready_i, s_r_last_o;
  axi_resp_t s_b_resp_o, s_r_resp_o;

  // Register model and expected responses in request order
  data_t     model_regs [`REG_COUNT];
  id_t       exp_b_id[$], exp_r_id[$];
  user_t     exp_b_user[$], exp_r_user[$];
  axi_resp_t exp_b_resp[$], exp_r_resp[$];
  data_t     exp_r_data[$];
  integer    seed = 94603;
  int        wr_acc = 0, wr_done = 0, rd_acc = 0, rd_done = 0;
  int        rst_cycles = 0;
  // Set at the transfer edge, cleared by the driver half a cycle later
  logic      aw_fired = 1'b0, ar_fired = 1'b0;

  axi_lite_subsys_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_mismatch(input string msg);
    $display("FAIL @%0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_low(input string what, input logic val);
    if (val !== 1'b0) report_mismatch($sformatf("%s not low around reset", what));
  endtask

  task automatic check_count(input string what, input int got, input int limit);
    if (got > limit) report_mismatch($sformatf("%s outstanding %0d above %0d", what, got, limit));
  endtask

  task automatic check_b(input id_t id, input user_t user, input axi_resp_t resp);
    if (s_b_id_o !== id) report_mismatch($sformatf("B id %0h expected %0h", s_b_id_o, id));
    if (s_b_user_o !== user)
      report_mismatch($sformatf("B user %0h expected %0h", s_b_user_o, user));
    if (s_b_resp_o !== resp)
      report_mismatch($sformatf("B resp %0h expected %0h", s_b_resp_o, resp));
  endtask

  task automatic check_r(input id_t id, input user_t user, input data_t data,
                         input axi_resp_t resp);
    if (s_r_id_o !== id) report_mismatch($sformatf("R id %0h expected %0h", s_r_id_o, id));
    if (s_r_user_o !== user)
      report_mismatch($sformatf("R user %0h expected %0h", s_r_user_o, user));
    if (s_r_data_o !== data)
      report_mismatch($sformatf("R data %0h expected %0h", s_r_data_o, data));
    if (s_r_resp_o !== resp)
      report_mismatch($sformatf("R resp %0h expected %0h", s_r_resp_o, resp));
    if (s_r_last_o !== 1'b1) report_mismatch("R last not set");
  endtask

  // Random byte address, mostly inside the bank
  function automatic addr_t pick_addr();
    int unsigned word;
    if ($unsigned($random(seed)) % 8 != 0) word = $unsigned($random(seed)) % `REG_COUNT;
    else word = `REG_COUNT + $unsigned($random(seed)) % ((1 << (`AXI_ADDR_W - 2)) - `REG_COUNT);
    return addr_t'({word, 2'($random(seed))});
  endfunction

  // Monitor samples handshakes at the rising edge, before state updates
  always @(posedge clk_i) begin : monitor
    int unsigned word;
    if (!arst_n_i || rst_cycles < 1) begin
      check_low("s_b_valid_o", s_b_valid_o);
      check_low("s_r_valid_o", s_r_valid_o);
      if (arst_n_i) rst_cycles++;
    end
    if (arst_n_i) begin
      // Responses first, they never belong to requests of this edge
      if (s_b_valid_o && s_b_ready_i) begin
        if (exp_b_id.size() == 0) abort_run("Write response arrived with no write pending");
        check_b(exp_b_id.pop_front(), exp_b_user.pop_front(), exp_b_resp.pop_front());
        wr_done++;
      end
      if (s_r_valid_o && s_r_ready_i) begin
        if (exp_r_id.size() == 0) abort_run("Read response arrived with no read pending");
        check_r(exp_r_id.pop_front(), exp_r_user.pop_front(), exp_r_data.pop_front(),
                exp_r_resp.pop_front());
        rd_done++;
      end
      // Reads see the registers as they stood before this edge
      if (s_ar_valid_i && s_ar_ready_o) begin
        word = s_ar_addr_i >> 2;
        exp_r_id.push_back(s_ar_id_i);
        exp_r_user.push_back(s_ar_user_i);
        exp_r_data.push_back(word < `REG_COUNT ? model_regs[word] : '0);
        exp_r_resp.push_back(word < `REG_COUNT ? RESP_OKAY : RESP_SLVERR);
        rd_acc++;
        ar_fired = 1'b1;
      end
      if ((s_w_valid_i && s_w_ready_o) != (s_aw_valid_i && s_aw_ready_o))
        abort_run("Write address and write data were not taken together");
      if (s_aw_valid_i && s_aw_ready_o) begin
        word = s_aw_addr_i >> 2;
        if (word < `REG_COUNT) begin
          for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
            if (s_w_strb_i[b]) model_regs[word][8*b +: 8] = s_w_data_i[8*b +: 8];
          end
        end
        exp_b_id.push_back(s_aw_id_i);
        exp_b_user.push_back(s_aw_user_i);
        exp_b_resp.push_back(word < `REG_COUNT ? RESP_OKAY : RESP_SLVERR);
        wr_acc++;
        aw_fired = 1'b1;
      end
      check_count("Write", wr_acc - wr_done, `AXI_PEND_WR);
      check_count("Read", rd_acc - rd_done, `AXI_PEND_RD);
    end
  end

  // Stimulus on the falling edge
  initial begin : driver
    int ops_left;
    int b_stall;
    int r_stall;
    int drain;
    ops_left = NUM_OPS;
    b_stall = 0;
    r_stall = 0;
    drain = 0;
    for (int i = 0; i < `REG_COUNT; i++) model_regs[i] = '0;
    arst_n_i = 1'b0;
    {s_aw_valid_i, s_w_valid_i, s_ar_valid_i, s_b_ready_i, s_r_ready_i} = '0;
    {s_aw_id_i, s_aw_addr_i, s_aw_user_i, s_w_data_i, s_w_strb_i} = '0;
    {s_ar_id_i, s_ar_addr_i, s_ar_user_i} = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);
    while (ops_left > 0 || s_aw_valid_i || s_ar_valid_i) begin
      if (aw_fired) begin
        s_aw_valid_i = 1'b0;
        s_w_valid_i  = 1'b0;
        aw_fired     = 1'b0;
      end
      if (ar_fired) begin
        s_ar_valid_i = 1'b0;
        ar_fired     = 1'b0;
      end
      // AW and W always start together
      if (!s_aw_valid_i && ops_left > 0 && $random(seed) % 2 == 0) begin
        s_aw_valid_i = 1'b1;
        s_w_valid_i  = 1'b1;
        s_aw_id_i    = $random(seed);
        s_aw_user_i  = $random(seed);
        s_aw_addr_i  = pick_addr();
        s_w_data_i   = $random(seed);
        s_w_strb_i   = $random(seed);
        ops_left--;
      end
      if (!s_ar_valid_i && ops_left > 0 && $random(seed) % 2 == 0) begin
        s_ar_valid_i = 1'b1;
        s_ar_id_i    = $random(seed);
        s_ar_user_i  = $random(seed);
        s_ar_addr_i  = pick_addr();
        ops_left--;
      end
      // Occasional long stalls let the outstanding counts fill up
      if (b_stall > 0) b_stall--;
      else if ($unsigned($random(seed)) % 64 == 0) b_stall = 10 + $unsigned($random(seed)) % 20;
      s_b_ready_i = (b_stall == 0) && ($unsigned($random(seed)) % 4 != 0);
      if (r_stall > 0) r_stall--;
      else if ($unsigned($random(seed)) % 64 == 0) r_stall = 10 + $unsigned($random(seed)) % 20;
      s_r_ready_i = (r_stall == 0) && ($unsigned($random(seed)) % 4 != 0);
      @(negedge clk_i);
    end
    // Both response channels open, pending responses must now drain
    s_b_ready_i = 1'b1;
    s_r_ready_i = 1'b1;
    while ((exp_b_id.size() != 0 || exp_r_id.size() != 0) && drain < DRAIN_CYCLES) begin
      @(negedge clk_i);
      drain++;
    end
    repeat (4) @(negedge clk_i);
    if (exp_b_id.size() != 0 || exp_r_id.size() != 0) begin
      $display("Expected responses were left over at the end of the run");
      $display("CHECKS FAILED");
      $fatal(1, "leftover responses");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  // Watchdog sized from the operation count
  initial begin : watchdog
    #(NUM_OPS * CYCLES_PER_OP * CLK_PERIOD);
    $display("Timeout: responses stopped arriving before all operations finished");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: hw/axi_lite_subsys_top.sv
// AXI to Lite bridge tile
`timescale 1ns/100ps

module axi_lite_subsys_top import axi_bridge_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // AXI4 slave port
  input  logic      s_aw_valid_i,
  output logic      s_aw_ready_o,
  input  id_t       s_aw_id_i,
  input  addr_t     s_aw_addr_i,
  input  user_t     s_aw_user_i,
  input  logic      s_w_valid_i,
  output logic      s_w_ready_o,
  input  data_t     s_w_data_i,
  input  strb_t     s_w_strb_i,
  output logic      s_b_valid_o,
  input  logic      s_b_ready_i,
  output id_t       s_b_id_o,
  output axi_resp_t s_b_resp_o,
  output user_t     s_b_user_o,
  input  logic      s_ar_valid_i,
  output logic      s_ar_ready_o,
  input  id_t       s_ar_id_i,
  input  addr_t     s_ar_addr_i,
  input  user_t     s_ar_user_i,
  output logic      s_r_valid_o,
  input  logic      s_r_ready_i,
  output id_t       s_r_id_o,
  output data_t     s_r_data_o,
  output axi_resp_t s_r_resp_o,
  output logic      s_r_last_o,
  output user_t     s_r_user_o
);

  // Lite link between adapter and bank
  logic      lite_aw_valid;
  logic      lite_aw_ready;
  addr_t     lite_aw_addr;
  logic      lite_w_valid;
  logic      lite_w_ready;
  data_t     lite_w_data;
  strb_t     lite_w_strb;
  logic      lite_b_valid;
  logic      lite_b_ready;
  axi_resp_t lite_b_resp;
  logic      lite_ar_valid;
  logic      lite_ar_ready;
  addr_t     lite_ar_addr;
  logic      lite_r_valid;
  logic      lite_r_ready;
  data_t     lite_r_data;
  axi_resp_t lite_r_resp;

  // ID and USER stripped here and restored on responses
  axi_to_lite_ctrl i_ctrl (
    .clk_i, .arst_n_i,
    .s_aw_valid_i, .s_aw_ready_o, .s_aw_id_i, .s_aw_addr_i, .s_aw_user_i,
    .s_w_valid_i, .s_w_ready_o, .s_w_data_i, .s_w_strb_i,
    .s_b_valid_o, .s_b_ready_i, .s_b_id_o, .s_b_resp_o, .s_b_user_o,
    .s_ar_valid_i, .s_ar_ready_o, .s_ar_id_i, .s_ar_addr_i, .s_ar_user_i,
    .s_r_valid_o, .s_r_ready_i, .s_r_id_o, .s_r_data_o, .s_r_resp_o,
    .s_r_last_o, .s_r_user_o,
    .m_aw_valid_o (lite_aw_valid),
    .m_aw_ready_i (lite_aw_ready),
    .m_aw_addr_o  (lite_aw_addr),
    .m_w_valid_o  (lite_w_valid),
    .m_w_ready_i  (lite_w_ready),
    .m_w_data_o   (lite_w_data),
    .m_w_strb_o   (lite_w_strb),
    .m_b_valid_i  (lite_b_valid),
    .m_b_ready_o  (lite_b_ready),
    .m_b_resp_i   (lite_b_resp),
    .m_ar_valid_o (lite_ar_valid),
    .m_ar_ready_i (lite_ar_ready),
    .m_ar_addr_o  (lite_ar_addr),
    .m_r_valid_i  (lite_r_valid),
    .m_r_ready_o  (lite_r_ready),
    .m_r_data_i   (lite_r_data),
    .m_r_resp_i   (lite_r_resp)
  );

  // Register bank answers every request locally
  lite_reg_bank i_bank (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .aw_valid_i (lite_aw_valid),
    .aw_ready_o (lite_aw_ready),
    .aw_addr_i  (lite_aw_addr),
    .w_valid_i  (lite_w_valid),
    .w_ready_o  (lite_w_ready),
    .w_data_i   (lite_w_data),
    .w_strb_i   (lite_w_strb),
    .b_valid_o  (lite_b_valid),
    .b_ready_i  (lite_b_ready),
    .b_resp_o   (lite_b_resp),
    .ar_valid_i (lite_ar_valid),
    .ar_ready_o (lite_ar_ready),
    .ar_addr_i  (lite_ar_addr),
    .r_valid_o  (lite_r_valid),
    .r_ready_i  (lite_r_ready),
    .r_data_o   (lite_r_data),
    .r_resp_o   (lite_r_resp)
  );

endmodule

// File: hw/lite_reg_bank.sv
// AXI4-Lite register bank
`timescale 1ns/100ps

`include "axi_lite_macros.svh"

module lite_reg_bank import axi_bridge_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // AW channel
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  addr_t     aw_addr_i,
  // W channel
  input  logic      w_valid_i,
  output logic      w_ready_o,
  input  data_t     w_data_i,
  input  strb_t     w_strb_i,
  // B channel
  output logic      b_valid_o,
  input  logic      b_ready_i,
  output axi_resp_t b_resp_o,
  // AR channel
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  addr_t     ar_addr_i,
  // R channel
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output data_t     r_data_o,
  output axi_resp_t r_resp_o
);

  // Word address drops the two byte-offset bits
  localparam int unsigned WORD_W = `AXI_ADDR_W - 2;
  localparam int unsigned IDX_W  = $clog2(`REG_COUNT);
  localparam int unsigned NBYTES = `AXI_DATA_W / 8;

  data_t             regs_q [`REG_COUNT];
  logic [WORD_W-1:0] wr_word;
  logic [WORD_W-1:0] rd_word;
  logic              wr_hit;
  logic              rd_hit;
  logic              wr_accept;
  logic              b_valid_q;
  axi_resp_t         b_resp_q;
  lite_r_t           rd_entry;
  lite_r_t           rd_head;
  logic              rd_full;
  logic              rd_empty;

  // Address decode
  assign wr_word = aw_addr_i[`AXI_ADDR_W-1:2];
  assign rd_word = ar_addr_i[`AXI_ADDR_W-1:2];
  assign wr_hit  = (wr_word < WORD_W'(`REG_COUNT));
  assign rd_hit  = (rd_word < WORD_W'(`REG_COUNT));

  // AW and W are taken together, one write at a time
  assign wr_accept  = aw_valid_i & w_valid_i & ~b_valid_q;
  assign aw_ready_o = w_valid_i & ~b_valid_q;
  assign w_ready_o  = aw_valid_i & ~b_valid_q;
  assign b_valid_o  = b_valid_q;
  assign b_resp_o   = b_resp_q;

  // Byte-merged register update, unmapped writes dropped
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_accept && wr_hit) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (w_strb_i[b]) begin
          regs_q[wr_word[IDX_W-1:0]][8*b +: 8] <= w_data_i[8*b +: 8];
        end
      end
    end
  end

  // B raised the cycle after the write, held until taken
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_accept) begin
      b_valid_q <= 1'b1;
    end else if (b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      b_resp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Read response captured at acceptance, zero data when unmapped
  always_comb begin
    rd_entry.data = rd_hit ? regs_q[rd_word[IDX_W-1:0]] : '0;
    rd_entry.resp = rd_hit ? RESP_OKAY : RESP_SLVERR;
  end

  // AR open whenever the queue has room
  assign ar_ready_o = ~rd_full;

  meta_fifo #(
    .dtype (lite_r_t),
    .DEPTH (`RD_QUEUE_DEPTH)
  ) i_rd_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (ar_valid_i & ~rd_full),
    .data_i   (rd_entry),
    .pop_i    (r_valid_o & r_ready_i),
    .data_o   (rd_head),
    .full_o   (rd_full),
    .empty_o  (rd_empty)
  );

  // R driven from the queue head
  assign r_valid_o = ~rd_empty;
  assign r_data_o  = rd_head.data;
  assign r_resp_o  = rd_head.resp;

  // A stalled B keeps its response code
  a_b_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else $error("B response changed while stalled");

endmodule

// File: hw/axi_to_lite_ctrl.sv
// AXI4 to AXI4-Lite adapter
`timescale 1ns/100ps

`include "axi_lite_macros.svh"

module axi_to_lite_ctrl import axi_bridge_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Slave AW channel
  input  logic      s_aw_valid_i,
  output logic      s_aw_ready_o,
  input  id_t       s_aw_id_i,
  input  addr_t     s_aw_addr_i,
  input  user_t     s_aw_user_i,
  // Slave W channel
  input  logic      s_w_valid_i,
  output logic      s_w_ready_o,
  input  data_t     s_w_data_i,
  input  strb_t     s_w_strb_i,
  // Slave B channel
  output logic      s_b_valid_o,
  input  logic      s_b_ready_i,
  output id_t       s_b_id_o,
  output axi_resp_t s_b_resp_o,
  output user_t     s_b_user_o,
  // Slave AR channel
  input  logic      s_ar_valid_i,
  output logic      s_ar_ready_o,
  input  id_t       s_ar_id_i,
  input  addr_t     s_ar_addr_i,
  input  user_t     s_ar_user_i,
  // Slave R channel
  output logic      s_r_valid_o,
  input  logic      s_r_ready_i,
  output id_t       s_r_id_o,
  output data_t     s_r_data_o,
  output axi_resp_t s_r_resp_o,
  output logic      s_r_last_o,
  output user_t     s_r_user_o,
  // Lite master side
  output logic      m_aw_valid_o,
  input  logic      m_aw_ready_i,
  output addr_t     m_aw_addr_o,
  output logic      m_w_valid_o,
  input  logic      m_w_ready_i,
  output data_t     m_w_data_o,
  output strb_t     m_w_strb_o,
  input  logic      m_b_valid_i,
  output logic      m_b_ready_o,
  input  axi_resp_t m_b_resp_i,
  output logic      m_ar_valid_o,
  input  logic      m_ar_ready_i,
  output addr_t     m_ar_addr_o,
  input  logic      m_r_valid_i,
  output logic      m_r_ready_o,
  input  data_t     m_r_data_i,
  input  axi_resp_t m_r_resp_i
);

  meta_t wr_meta_head;
  meta_t rd_meta_head;
  logic  wr_full;
  logic  wr_empty;
  logic  rd_full;
  logic  rd_empty;

  // Write metadata, pushed on AW and popped on B
  meta_fifo #(
    .dtype (meta_t),
    .DEPTH (`AXI_PEND_WR)
  ) i_wr_meta_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (s_aw_valid_i & s_aw_ready_o),
    .data_i   ('{id: s_aw_id_i, user: s_aw_user_i}),
    .pop_i    (s_b_valid_o & s_b_ready_i),
    .data_o   (wr_meta_head),
    .full_o   (wr_full),
    .empty_o  (wr_empty)
  );

  // Read metadata, pushed on AR and popped on R
  meta_fifo #(
    .dtype (meta_t),
    .DEPTH (`AXI_PEND_RD)
  ) i_rd_meta_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (s_ar_valid_i & s_ar_ready_o),
    .data_i   ('{id: s_ar_id_i, user: s_ar_user_i}),
    .pop_i    (s_r_valid_o & s_r_ready_i),
    .data_o   (rd_meta_head),
    .full_o   (rd_full),
    .empty_o  (rd_empty)
  );

  // Address channels close while the matching FIFO is full
  assign m_aw_valid_o = s_aw_valid_i & ~wr_full;
  assign s_aw_ready_o = m_aw_ready_i & ~wr_full;
  assign m_aw_addr_o  = s_aw_addr_i;
  assign m_ar_valid_o = s_ar_valid_i & ~rd_full;
  assign s_ar_ready_o = m_ar_ready_i & ~rd_full;
  assign m_ar_addr_o  = s_ar_addr_i;

  // Write data passes straight through
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;
  assign m_w_data_o  = s_w_data_i;
  assign m_w_strb_o  = s_w_strb_i;

  // Responses get id and user back from the FIFO heads
  assign s_b_valid_o = m_b_valid_i;
  assign m_b_ready_o = s_b_ready_i;
  assign s_b_resp_o  = m_b_resp_i;
  assign s_b_id_o    = wr_meta_head.id;
  assign s_b_user_o  = wr_meta_head.user;
  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_resp_o  = m_r_resp_i;
  // Single-beat reads only
  assign s_r_last_o  = 1'b1;
  assign s_r_id_o    = rd_meta_head.id;
  assign s_r_user_o  = rd_meta_head.user;

  // Bank never answers a request the adapter did not forward
  a_b_has_meta: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_b_valid_i |-> !wr_empty)
    else $error("B response without stored write metadata");

  a_r_has_meta: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_r_valid_i |-> !rd_empty)
    else $error("R response without stored read metadata");

endmodule

// File: hw/meta_fifo.sv
// Small synchronous FIFO
`timescale 1ns/100ps

module meta_fifo #(
  // Payload type of one entry
  parameter type         dtype = logic,
  // Number of entries
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic arst_n_i,
  // Write side
  input  logic push_i,
  input  dtype data_i,
  // Read side
  input  logic pop_i,
  output dtype data_o,
  // Status flags
  output logic full_o,
  output logic empty_o
);

  // Pointers keep at least one bit for a single-entry FIFO
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // Count must reach DEPTH itself
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  dtype             mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Flags straight from occupancy
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  // Head entry is always visible
  assign data_o  = mem_q[rd_ptr_q];

  // Entry write at the tail
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at DEPTH, not at a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count unchanged
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Users gate push on room and pop on data
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o)
    else $error("meta_fifo push while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o)
    else $error("meta_fifo pop while empty");

endmodule

// File: hw/axi_bridge_pkg.sv
// AXI bridge shared types
`include "axi_lite_macros.svh"

package axi_bridge_pkg;

  // Bus field types
  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_DATA_W-1:0]   data_t;
  // One strobe bit per data byte
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_ID_W-1:0]     id_t;
  typedef logic [`AXI_USER_W-1:0]   user_t;

  // Response codes used by the register bank
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // Per-transaction metadata held by the adapter
  // Stripped on the way in, restored on B and R
  typedef struct packed {
    id_t   id;
    user_t user;
  } meta_t;

  // One queued read response inside the bank
  typedef struct packed {
    data_t     data;
    axi_resp_t resp;
  } lite_r_t;

endpackage

// File: hw/axi_lite_macros.svh
// AXI bridge tile widths
`ifndef AXI_LITE_MACROS_SVH
`define AXI_LITE_MACROS_SVH

// Byte address width of both ports
`define AXI_ADDR_W 12
// Data width of both ports
`define AXI_DATA_W 32
// Transaction ID width on the AXI4 side
`define AXI_ID_W 4
// User sideband width on the AXI4 side
`define AXI_USER_W 2

// Outstanding transactions the adapter can track
`define AXI_PEND_RD 4
`define AXI_PEND_WR 4

// Register bank size in 32-bit words
`define REG_COUNT 16
// Read responses the bank can hold before it stalls AR
`define RD_QUEUE_DEPTH 2

`endif
